//--- rtl/sbox_cfg.svh
`ifndef SBOX_CFG_SVH
`define SBOX_CFG_SVH

// Edges from input sample to visible result
`define SBOX_LATENCY 6

// Register stages inside the masked GF(2^4) inverter
`define SBOX_INV_STAGES 2

`define SBOX_AFFINE_C 8'h63

// Scaling constant of the GF(2^8)/GF(2^4) tower polynomial y^2 + y + lambda
`define SBOX_TOWER_LAMBDA 4'h8

`endif

//--- rtl/gfTypesPkg.sv
`include "sbox_cfg.svh"

package gfTypesPkg;

    // Share 0 sits in the low bits
    typedef struct packed {
        logic [7:0] s1;
        logic [7:0] s0;
    } sharedByteT;

    typedef struct packed {
        logic [3:0] s1;
        logic [3:0] s0;
    } sharedNibT;

    typedef struct packed {
        logic [1:0] s1;
        logic [1:0] s0;
    } sharedCrumbT;

    // GF(2^2) with w^2 = w + 1, bit 1 is the w coefficient
    function automatic logic [1:0] gf2Mul(logic [1:0] a, logic [1:0] b);
        logic hh;
        hh = a[1] & b[1];
        return {hh ^ (a[1] & b[0]) ^ (a[0] & b[1]), hh ^ (a[0] & b[0])};
    endfunction

    // N * x^2 with N = w, reduces to a bit swap
    function automatic logic [1:0] gf2SqSc(logic [1:0] x);
        return {x[0], x[1]};
    endfunction

    // GF(2^4) over GF(2^2) with z^2 = z + N, high crumb is the z coefficient
    function automatic logic [3:0] gf4Mul(logic [3:0] a, logic [3:0] b);
        logic [1:0] hh;
        logic [1:0] hi;
        logic [1:0] lo;
        hh = gf2Mul(a[3:2], b[3:2]);
        hi = hh ^ gf2Mul(a[3:2], b[1:0]) ^ gf2Mul(a[1:0], b[3:2]);
        lo = gf2Mul(2'b10, hh) ^ gf2Mul(a[1:0], b[1:0]);
        return {hi, lo};
    endfunction

    // lambda * x^2
    function automatic logic [3:0] gf4SqSc(logic [3:0] x);
        return gf4Mul(`SBOX_TOWER_LAMBDA, gf4Mul(x, x));
    endfunction

endpackage

//--- rtl/maskRndPkg.sv
package maskRndPkg;

    // Fresh randomness, one full set per clock
    typedef struct packed {
        logic [7:0] zSqscMul; // Square-scale multiplier
        logic [3:0] zInv1;    // Inverter norm
        logic [3:0] zInv2;    // Inverter high output
        logic [3:0] zInv3;    // Inverter low output
        logic [7:0] zMulHi;   // Final multiply, high nibble
        logic [7:0] zMulLo;   // Final multiply, low nibble
    } sboxRndT;

endpackage

//--- rtl/linearMap.sv
`timescale 1ns/1ps
`include "sbox_cfg.svh"

module linearMap #(
    parameter int matrixSel = 1 // 1: AES to tower, 0: tower to AES incl. affine matrix
) (
    input  logic [7:0] a,
    output logic [7:0] b
);

    // Tower product in the normal basis {y, y^16}
    function automatic logic [7:0] towerMul(logic [7:0] p, logic [7:0] q);
        logic [3:0] hh;
        logic [3:0] ll;
        logic [3:0] t;
        hh = gfTypesPkg::gf4Mul(p[7:4], q[7:4]);
        ll = gfTypesPkg::gf4Mul(p[3:0], q[3:0]);
        t  = gfTypesPkg::gf4Mul(`SBOX_TOWER_LAMBDA,
                                gfTypesPkg::gf4Mul(p[7:4] ^ p[3:0], q[7:4] ^ q[3:0]));
        return {hh ^ t, ll ^ t};
    endfunction

    function automatic logic [7:0] applyCols(logic [7:0][7:0] cols, logic [7:0] v);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < 8; i++) begin
            if (v[i]) r ^= cols[i];
        end
        return r;
    endfunction

    // Linear part of the AES affine transform
    function automatic logic [7:0] affineLin(logic [7:0] v);
        return v ^ {v[6:0], v[7]} ^ {v[5:0], v[7:6]} ^ {v[4:0], v[7:5]} ^ {v[3:0], v[7:4]};
    endfunction

    function automatic logic [7:0][7:0] buildMatrix(int sel);
        logic [7:0][7:0] fwd;
        logic [7:0][7:0] res;
        logic [7:0] beta;
        logic [7:0] c2;
        logic [7:0] c4;
        logic [7:0] img;
        beta = '0;
        // Root of x^8 + x^4 + x^3 + x + 1 in the tower field, one is 8'h11
        for (int c = 255; c >= 2; c--) begin
            c2 = towerMul(c[7:0], c[7:0]);
            c4 = towerMul(c2, c2);
            if ((towerMul(c4, c4) ^ c4 ^ towerMul(c2, c[7:0]) ^ c[7:0] ^ 8'h11) == 8'h00) begin
                beta = c[7:0];
            end
        end
        fwd[0] = 8'h11;
        for (int i = 1; i < 8; i++) begin
            fwd[i] = towerMul(fwd[i-1], beta);
        end
        res = fwd;
        if (sel == 0) begin
            // Invert by search and fold in the affine matrix
            for (int v = 0; v < 256; v++) begin
                img = applyCols(fwd, v[7:0]);
                for (int j = 0; j < 8; j++) begin
                    if (img == (8'h01 << j)) res[j] = affineLin(v[7:0]);
                end
            end
        end
        return res;
    endfunction

    localparam logic [7:0][7:0] Cols = buildMatrix(matrixSel);

    assign b = applyCols(Cols, a);

endmodule

//--- rtl/domMulGf4.sv
`timescale 1ns/1ps

module domMulGf4 #(
    parameter bit sqsc = 1'b0 // Add lambda*(x+y)^2 per domain
) (
    input  logic                  ClkxCI,
    input  logic                  RstxBI,
    input  gfTypesPkg::sharedNibT x,
    input  gfTypesPkg::sharedNibT y,
    input  logic [7:0]            z,
    output gfTypesPkg::sharedNibT q
);

    gfTypesPkg::sharedNibT innerD;
    gfTypesPkg::sharedNibT innerQ;
    gfTypesPkg::sharedNibT crossD;
    gfTypesPkg::sharedNibT crossQ;
    logic [3:0] sq0;
    logic [3:0] sq1;

    // Linear term stays inside its own domain
    assign sq0 = sqsc ? gfTypesPkg::gf4SqSc(x.s0 ^ y.s0) : 4'h0;
    assign sq1 = sqsc ? gfTypesPkg::gf4SqSc(x.s1 ^ y.s1) : 4'h0;

    // z[7:4] refreshes both domains and cancels in the sum
    assign innerD.s0 = gfTypesPkg::gf4Mul(x.s0, y.s0) ^ sq0 ^ z[7:4];
    assign innerD.s1 = gfTypesPkg::gf4Mul(x.s1, y.s1) ^ sq1 ^ z[7:4];

    // Cross-domain products, remasked before the register
    assign crossD.s0 = gfTypesPkg::gf4Mul(x.s0, y.s1) ^ z[3:0];
    assign crossD.s1 = gfTypesPkg::gf4Mul(x.s1, y.s0) ^ z[3:0];

    always_ff @(posedge ClkxCI or negedge RstxBI) begin
        if (!RstxBI) begin
            innerQ <= '0;
            crossQ <= '0;
        end else begin
            innerQ <= innerD;
            crossQ <= crossD;
        end
    end

    // Compression after the register
    assign q.s0 = innerQ.s0 ^ crossQ.s0;
    assign q.s1 = innerQ.s1 ^ crossQ.s1;

endmodule

//--- rtl/domInverterGf4.sv
`timescale 1ns/1ps
`include "sbox_cfg.svh"

module domInverterGf4 (
    input  logic                  ClkxCI,
    input  logic                  RstxBI,
    input  gfTypesPkg::sharedNibT x,
    input  logic [3:0]            z1,
    input  logic [3:0]            z2,
    input  logic [3:0]            z3,
    output gfTypesPkg::sharedNibT q
);

    localparam int DlyLast = `SBOX_INV_STAGES - 2;

    gfTypesPkg::sharedCrumbT nInnerD, nInnerQ, nCrossD, nCrossQ;
    gfTypesPkg::sharedCrumbT dInv;
    gfTypesPkg::sharedCrumbT hInnerD, hInnerQ, hCrossD, hCrossQ;
    gfTypesPkg::sharedCrumbT lInnerD, lInnerQ, lCrossD, lCrossQ;
    gfTypesPkg::sharedNibT   xDly [`SBOX_INV_STAGES-1];
    logic [1:0] ah0, ah1, al0, al1;
    logic [1:0] rh0, rh1, rs0, rs1;

    assign ah0 = x.s0[3:2];
    assign al0 = x.s0[1:0];
    assign ah1 = x.s1[3:2];
    assign al1 = x.s1[1:0];

    // Norm N*ah^2 + ah*al + al^2, squares stay in their domain
    assign nInnerD.s0 = gfTypesPkg::gf2Mul(ah0, al0) ^ gfTypesPkg::gf2SqSc(ah0)
                      ^ gfTypesPkg::gf2Mul(al0, al0) ^ z1[3:2];
    assign nInnerD.s1 = gfTypesPkg::gf2Mul(ah1, al1) ^ gfTypesPkg::gf2SqSc(ah1)
                      ^ gfTypesPkg::gf2Mul(al1, al1) ^ z1[3:2];
    assign nCrossD.s0 = gfTypesPkg::gf2Mul(ah0, al1) ^ z1[1:0];
    assign nCrossD.s1 = gfTypesPkg::gf2Mul(ah1, al0) ^ z1[1:0];

    always_ff @(posedge ClkxCI or negedge RstxBI) begin
        if (!RstxBI) begin
            nInnerQ <= '0;
            nCrossQ <= '0;
            for (int i = 0; i <= DlyLast; i++) xDly[i] <= '0;
        end else begin
            nInnerQ <= nInnerD;
            nCrossQ <= nCrossD;
            xDly[0] <= x;
            for (int i = 1; i <= DlyLast; i++) xDly[i] <= xDly[i-1];
        end
    end

    // Inverse in GF(2^2) is the square, linear per share
    assign dInv.s0 = gfTypesPkg::gf2Mul(nInnerQ.s0 ^ nCrossQ.s0, nInnerQ.s0 ^ nCrossQ.s0);
    assign dInv.s1 = gfTypesPkg::gf2Mul(nInnerQ.s1 ^ nCrossQ.s1, nInnerQ.s1 ^ nCrossQ.s1);

    assign rh0 = xDly[DlyLast].s0[3:2];
    assign rh1 = xDly[DlyLast].s1[3:2];
    assign rs0 = rh0 ^ xDly[DlyLast].s0[1:0]; // ah + al, conjugate low part
    assign rs1 = rh1 ^ xDly[DlyLast].s1[1:0];

    assign hInnerD.s0 = gfTypesPkg::gf2Mul(rh0, dInv.s0) ^ z2[3:2];
    assign hInnerD.s1 = gfTypesPkg::gf2Mul(rh1, dInv.s1) ^ z2[3:2];
    assign hCrossD.s0 = gfTypesPkg::gf2Mul(rh0, dInv.s1) ^ z2[1:0];
    assign hCrossD.s1 = gfTypesPkg::gf2Mul(rh1, dInv.s0) ^ z2[1:0];

    assign lInnerD.s0 = gfTypesPkg::gf2Mul(rs0, dInv.s0) ^ z3[3:2];
    assign lInnerD.s1 = gfTypesPkg::gf2Mul(rs1, dInv.s1) ^ z3[3:2];
    assign lCrossD.s0 = gfTypesPkg::gf2Mul(rs0, dInv.s1) ^ z3[1:0];
    assign lCrossD.s1 = gfTypesPkg::gf2Mul(rs1, dInv.s0) ^ z3[1:0];

    always_ff @(posedge ClkxCI or negedge RstxBI) begin
        if (!RstxBI) begin
            hInnerQ <= '0;
            hCrossQ <= '0;
            lInnerQ <= '0;
            lCrossQ <= '0;
        end else begin
            hInnerQ <= hInnerD;
            hCrossQ <= hCrossD;
            lInnerQ <= lInnerD;
            lCrossQ <= lCrossD;
        end
    end

    assign q.s0 = {hInnerQ.s0 ^ hCrossQ.s0, lInnerQ.s0 ^ lCrossQ.s0};
    assign q.s1 = {hInnerQ.s1 ^ hCrossQ.s1, lInnerQ.s1 ^ lCrossQ.s1};

endmodule

//--- rtl/sboxInput.sv
`timescale 1ns/1ps

module sboxInput (
    input  logic                   ClkxCI,
    input  logic                   RstxBI,
    input  gfTypesPkg::sharedByteT xShares,
    output gfTypesPkg::sharedByteT mapped
);

    logic [7:0] map0;
    logic [7:0] map1;

    // Basis change is linear, so each share maps on its own
    linearMap #(.matrixSel(1)) i_map0 (.a(xShares.s0), .b(map0));
    linearMap #(.matrixSel(1)) i_map1 (.a(xShares.s1), .b(map1));

    always_ff @(posedge ClkxCI or negedge RstxBI) begin
        if (!RstxBI) begin
            mapped <= '0;
        end else begin
            mapped.s0 <= map0;
            mapped.s1 <= map1;
        end
    end

endmodule

//--- rtl/gf256InvPipe.sv
`timescale 1ns/1ps
`include "sbox_cfg.svh"

module gf256InvPipe (
    input  logic                   ClkxCI,
    input  logic                   RstxBI,
    input  gfTypesPkg::sharedByteT mapped,
    input  maskRndPkg::sboxRndT    rnd,
    output gfTypesPkg::sharedByteT inv
);

    localparam int DlyLen = `SBOX_INV_STAGES + 1;

    gfTypesPkg::sharedNibT hiIn;
    gfTypesPkg::sharedNibT loIn;
    gfTypesPkg::sharedNibT delta;
    gfTypesPkg::sharedNibT deltaInv;
    gfTypesPkg::sharedNibT invHi;
    gfTypesPkg::sharedNibT invLo;
    gfTypesPkg::sharedNibT hiDly [DlyLen];
    gfTypesPkg::sharedNibT loDly [DlyLen];

    assign hiIn.s0 = mapped.s0[7:4];
    assign hiIn.s1 = mapped.s1[7:4];
    assign loIn.s0 = mapped.s0[3:0];
    assign loIn.s1 = mapped.s1[3:0];

    // Norm lambda*(ah+al)^2 + ah*al
    domMulGf4 #(.sqsc(1'b1)) i_sqscMul (
        .ClkxCI(ClkxCI), .RstxBI(RstxBI),
        .x(hiIn), .y(loIn), .z(rnd.zSqscMul), .q(delta)
    );

    domInverterGf4 i_inv (
        .ClkxCI(ClkxCI), .RstxBI(RstxBI),
        .x(delta), .z1(rnd.zInv1), .z2(rnd.zInv2), .z3(rnd.zInv3), .q(deltaInv)
    );

    // Keep the nibbles in step with the norm and its inverse
    always_ff @(posedge ClkxCI or negedge RstxBI) begin
        if (!RstxBI) begin
            for (int i = 0; i < DlyLen; i++) begin
                hiDly[i] <= '0;
                loDly[i] <= '0;
            end
        end else begin
            hiDly[0] <= hiIn;
            loDly[0] <= loIn;
            for (int i = 1; i < DlyLen; i++) begin
                hiDly[i] <= hiDly[i-1];
                loDly[i] <= loDly[i-1];
            end
        end
    end

    // Conjugate times inverse norm, halves swap places
    domMulGf4 #(.sqsc(1'b0)) i_mulHi (
        .ClkxCI(ClkxCI), .RstxBI(RstxBI),
        .x(deltaInv), .y(loDly[DlyLen-1]), .z(rnd.zMulHi), .q(invHi)
    );

    domMulGf4 #(.sqsc(1'b0)) i_mulLo (
        .ClkxCI(ClkxCI), .RstxBI(RstxBI),
        .x(deltaInv), .y(hiDly[DlyLen-1]), .z(rnd.zMulLo), .q(invLo)
    );

    assign inv.s0 = {invHi.s0, invLo.s0};
    assign inv.s1 = {invHi.s1, invLo.s1};

endmodule

//--- rtl/sboxOutput.sv
`timescale 1ns/1ps
`include "sbox_cfg.svh"

module sboxOutput (
    input  logic                   ClkxCI,
    input  logic                   RstxBI,
    input  gfTypesPkg::sharedByteT inv,
    output gfTypesPkg::sharedByteT qShares
);

    logic [7:0] aes0;
    logic [7:0] aes1;
    logic [`SBOX_LATENCY-2:0] fillSr; // Ones shift in after reset release

    // Back to AES basis with the affine matrix folded in
    linearMap #(.matrixSel(0)) i_map0 (.a(inv.s0), .b(aes0));
    linearMap #(.matrixSel(0)) i_map1 (.a(inv.s1), .b(aes1));

    always_ff @(posedge ClkxCI or negedge RstxBI) begin
        if (!RstxBI) begin
            fillSr  <= '0;
            qShares <= '0;
        end else begin
            fillSr <= {fillSr[`SBOX_LATENCY-3:0], 1'b1};
            if (fillSr[`SBOX_LATENCY-2]) begin
                qShares.s0 <= aes0 ^ `SBOX_AFFINE_C; // Constant on one share only
                qShares.s1 <= aes1;
            end else begin
                qShares <= '0; // Earlier stages still carry reset values
            end
        end
    end

endmodule

//--- rtl/maskedSbox.sv
`timescale 1ns/1ps

module maskedSbox (
    input  logic                   ClkxCI,
    input  logic                   RstxBI,
    input  gfTypesPkg::sharedByteT xShares,
    input  maskRndPkg::sboxRndT    rnd,
    output gfTypesPkg::sharedByteT qShares
);

    gfTypesPkg::sharedByteT mappedShares;
    gfTypesPkg::sharedByteT invShares;

    sboxInput i_input (
        .ClkxCI(ClkxCI), .RstxBI(RstxBI),
        .xShares(xShares), .mapped(mappedShares)
    );

    gf256InvPipe i_invPipe (
        .ClkxCI(ClkxCI), .RstxBI(RstxBI),
        .mapped(mappedShares), .rnd(rnd), .inv(invShares)
    );

    sboxOutput i_output (
        .ClkxCI(ClkxCI), .RstxBI(RstxBI),
        .inv(invShares), .qShares(qShares)
    );

endmodule

//--- bench/maskedSbox_properties.sv
`timescale 1ns/1ps
`include "sbox_cfg.svh"

module maskedSbox_properties (
    input logic                   ClkxCI,
    input logic                   RstxBI,
    input gfTypesPkg::sharedByteT xShares,
    input gfTypesPkg::sharedByteT qShares
);

    localparam int Lat = `SBOX_LATENCY;

    // AES S-box, entry 0 in the top bits
    localparam logic [0:255][7:0] SboxTable = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    logic [7:0] secretIn;
    logic [7:0] unmasked;
    int         sinceRst;
    logic       rstFail   = 1'b0;
    logic       valueFail = 1'b0;
    logic       zeroFail  = 1'b0;
    logic       maskFail  = 1'b0;
    logic       dropFail  = 1'b0;
    logic       errSeen;

    assign secretIn = xShares.s0 ^ xShares.s1;
    assign unmasked = qShares.s0 ^ qShares.s1;
    assign errSeen  = rstFail | valueFail | zeroFail | maskFail | dropFail; // Read by the testbench

    // Edges since reset release, saturating
    always_ff @(posedge ClkxCI or negedge RstxBI) begin
        if (!RstxBI) begin
            sinceRst <= 0;
        end else if (sinceRst < Lat + 2) begin
            sinceRst <= sinceRst + 1;
        end
    end

    resetZero: assert property (@(posedge ClkxCI) sinceRst < Lat |-> qShares == '0)
        else begin
            rstFail = 1'b1;
            $error("error %0t: output shares not zero during or right after reset", $time);
        end

    sboxValue: assert property (@(posedge ClkxCI)
        sinceRst >= Lat |-> unmasked == SboxTable[$past(secretIn, Lat)])
        else begin
            valueFail = 1'b1;
            $error("error %0t: unmasked output differs from the S-box table", $time);
        end

    // Zero has no inverse and lands on the affine constant
    zeroInput: assert property (@(posedge ClkxCI)
        sinceRst >= Lat && $past(secretIn, Lat) == 8'h00 |-> unmasked == `SBOX_AFFINE_C)
        else begin
            zeroFail = 1'b1;
            $error("error %0t: zero input did not give the affine constant", $time);
        end

    maskIndep: assert property (@(posedge ClkxCI)
        sinceRst > Lat && $past(secretIn, Lat) == $past(secretIn, Lat + 1)
        |-> unmasked == $past(unmasked))
        else begin
            maskFail = 1'b1;
            $error("error %0t: same secret under another mask gave another result", $time);
        end

    // S-box is a bijection, so distinct inputs must show distinct outputs
    noDrop: assert property (@(posedge ClkxCI)
        sinceRst > Lat && $past(secretIn, Lat) != $past(secretIn, Lat + 1)
        |-> unmasked != $past(unmasked))
        else begin
            dropFail = 1'b1;
            $error("error %0t: back-to-back inputs gave a repeated result", $time);
        end

endmodule

//--- bench/tbMaskedSbox.sv
`timescale 1ns/1ps
`include "sbox_cfg.svh"

module tbMaskedSbox;

    localparam int HalfPeriod = 10;
    localparam int RstCycles  = 16;
    localparam int RandCycles = 600;
    localparam int CycleLimit = RstCycles + 700 + `SBOX_LATENCY + 20;

    localparam logic [7:0] SplitMasks [6] = '{8'h00, 8'h01, 8'hff, 8'ha5, 8'h3c, 8'h53};

    logic                   ClkxCI;
    logic                   RstxBI;
    gfTypesPkg::sharedByteT xShares;
    maskRndPkg::sboxRndT    rnd;
    gfTypesPkg::sharedByteT qShares;
    logic [31:0]            lcgState;
    int                     cycleCnt = 0;

    maskedSbox i_dut (
        .ClkxCI(ClkxCI), .RstxBI(RstxBI),
        .xShares(xShares), .rnd(rnd), .qShares(qShares)
    );

    // Reference checks attached to the DUT
    bind maskedSbox maskedSbox_properties i_props (
        .ClkxCI(ClkxCI), .RstxBI(RstxBI),
        .xShares(xShares), .qShares(qShares)
    );

    initial ClkxCI = 1'b0;
    always #HalfPeriod ClkxCI = ~ClkxCI;

    function automatic logic [31:0] lcgNext(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic drawWord(output logic [31:0] w);
        lcgState = lcgNext(lcgState);
        w = lcgState;
    endtask

    // Drive one byte with fresh rnd, return 2 ns after the next edge
    task automatic applyByte(input logic [7:0] secret, input logic [7:0] mask);
        logic [31:0] w0;
        logic [31:0] w1;
        drawWord(w0);
        drawWord(w1);
        xShares.s1 = mask;
        xShares.s0 = secret ^ mask;
        rnd        = {w0, w1[31:28]};
        @(posedge ClkxCI);
        #2;
    endtask

    task automatic applyRandom();
        logic [31:0] w;
        drawWord(w);
        applyByte(w[31:24], w[23:16]); // Upper LCG bits are the better ones
    endtask

    always @(posedge ClkxCI) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= CycleLimit) begin
            $display("Simulation failed");
            $fatal(1, "Timeout, the test phases did not finish within %0d cycles", CycleLimit);
        end
    end

    // Assertion results are stable by the falling edge
    always @(negedge ClkxCI) begin
        if (i_dut.i_props.errSeen) begin
            $display("Simulation failed");
            $fatal(1, "A DUT assertion failed, run stopped at the first error");
        end
    end

    initial begin
        logic [31:0] w;
        RstxBI   = 1'b0;
        xShares  = '0;
        rnd      = '0;
        lcgState = 32'h1363;
        repeat (RstCycles) @(posedge ClkxCI);
        #2;
        RstxBI = 1'b1;

        repeat (RandCycles) applyRandom();

        // Zero and all ones, a few splits each
        applyByte(8'h00, 8'h00);
        applyByte(8'h00, 8'h5a);
        applyByte(8'h00, 8'hff);
        applyByte(8'hff, 8'h00);
        applyByte(8'hff, 8'h81);
        applyByte(8'hff, 8'hff);

        for (int i = 0; i < 6; i++) begin
            applyByte(8'h53, SplitMasks[i]); // Last split leaves share 0 at zero
        end

        // Distinct bytes back to back
        for (int i = 0; i < 16; i++) begin
            drawWord(w);
            applyByte(8'h10 + 8'(i), w[31:24]);
        end

        repeat (`SBOX_LATENCY + 2) applyRandom(); // Drain, checks stay live

        @(negedge ClkxCI);
        if (i_dut.i_props.errSeen) begin
            $display("Simulation failed");
            $fatal(1, "A DUT assertion failed in the last cycle");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

//--- maskedSbox.f
+incdir+rtl
rtl/gfTypesPkg.sv
rtl/maskRndPkg.sv
rtl/linearMap.sv
rtl/domMulGf4.sv
rtl/domInverterGf4.sv
rtl/sboxInput.sv
rtl/gf256InvPipe.sv
rtl/sboxOutput.sv
rtl/maskedSbox.sv
bench/maskedSbox_properties.sv
bench/tbMaskedSbox.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tbMaskedSbox -f maskedSbox.f -o simMaskedSbox &&
./obj_dir/simMaskedSbox +verilator+error+limit+100 || exit 1
